/* flist.f */
mem_pkg.sv
pipe_pkg.sv
load_align.sv
mem1_stage.sv
mem_stage.sv
wb_stage.sv
mem_subsystem.sv
tb_mem_subsystem.sv

/* load_align.sv */
`timescale 1ns/1ps

module load_align (
    input  logic [mem_pkg::OP_WD-1:0]     mem_op,
    input  logic [mem_pkg::OFFSET_WD-1:0] offset,
    input  logic [mem_pkg::DATA_WD-1:0]   rdata,
    input  logic [mem_pkg::DATA_WD-1:0]   rt_value,
    output logic [mem_pkg::DATA_WD-1:0]   load_data
);

    logic [7:0]  byte_sel;
    logic [15:0] half_sel;

    assign byte_sel = rdata[{offset, 3'b000} +: 8];
    assign half_sel = offset[1] ? rdata[31:16] : rdata[15:0];

    always_comb begin
        case (mem_op)
            mem_pkg::OP_LB:  load_data = {{24{byte_sel[7]}}, byte_sel};
            mem_pkg::OP_LBU: load_data = {24'd0, byte_sel};
            mem_pkg::OP_LH:  load_data = {{16{half_sel[15]}}, half_sel};
            mem_pkg::OP_LHU: load_data = {16'd0, half_sel};
            mem_pkg::OP_LWL: begin
                // memory bytes 0..offset fill rt from the top
                case (offset)
                    2'd0:    load_data = {rdata[7:0], rt_value[23:0]};
                    2'd1:    load_data = {rdata[15:0], rt_value[15:0]};
                    2'd2:    load_data = {rdata[23:0], rt_value[7:0]};
                    default: load_data = rdata;
                endcase
            end
            mem_pkg::OP_LWR: begin
                // memory bytes offset..3 fill rt from the bottom
                case (offset)
                    2'd0:    load_data = rdata;
                    2'd1:    load_data = {rt_value[31:24], rdata[31:8]};
                    2'd2:    load_data = {rt_value[31:16], rdata[31:16]};
                    default: load_data = {rt_value[31:8], rdata[31:24]};
                endcase
            end
            default: load_data = rdata;   // lw
        endcase
    end

endmodule

/* mem1_stage.sv */
`timescale 1ns/1ps

module mem1_stage (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           es_to_m1s_valid,
    input  logic [pipe_pkg::M1_BUS_WD-1:0] es_to_m1s_bus,
    input  logic                           ms_allowin,
    output logic                           m1s_allowin,
    output logic                           m1s_to_ms_valid,
    output logic [pipe_pkg::MS_BUS_WD-1:0] m1s_to_ms_bus,
    output logic                           data_req,
    output logic                           data_wr,
    output logic [mem_pkg::DATA_WD-1:0]    data_addr,
    output logic [mem_pkg::STRB_WD-1:0]    data_wstrb,
    output logic [mem_pkg::DATA_WD-1:0]    data_wdata
);

    logic                           m1s_valid;
    logic [pipe_pkg::M1_BUS_WD-1:0] m1s_bus_r;
    logic [mem_pkg::OP_WD-1:0]      m1s_op;
    logic                           m1s_ex;
    logic [mem_pkg::DATA_WD-1:0]    m1s_rt_value;
    logic [mem_pkg::DATA_WD-1:0]    m1s_addr;
    logic [mem_pkg::OFFSET_WD-1:0]  m1s_offset;
    logic                           m1s_access;
    logic                           m1s_store_flow;

    assign m1s_op       = m1s_bus_r[pipe_pkg::OP_LO +: mem_pkg::OP_WD];
    assign m1s_ex       = m1s_bus_r[pipe_pkg::EX_LO];
    assign m1s_rt_value = m1s_bus_r[pipe_pkg::RT_LO +: mem_pkg::DATA_WD];
    assign m1s_addr     = m1s_bus_r[pipe_pkg::RESULT_LO +: mem_pkg::DATA_WD];
    assign m1s_offset   = m1s_addr[mem_pkg::OFFSET_WD-1:0];

    // always ready once the item is held
    assign m1s_allowin     = !m1s_valid || ms_allowin;
    assign m1s_to_ms_valid = m1s_valid;

    always_ff @(posedge clk) begin
        if (reset) begin
            m1s_valid <= 1'b0;
        end else if (m1s_allowin) begin
            m1s_valid <= es_to_m1s_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (es_to_m1s_valid && m1s_allowin) begin
            m1s_bus_r <= es_to_m1s_bus;
        end
    end

    // excepted items and non-loads never wait on the cache in mem
    assign m1s_access     = (m1s_op != mem_pkg::OP_NONE) && !m1s_ex;
    assign m1s_store_flow = !mem_pkg::is_load(m1s_op) || m1s_ex;
    assign m1s_to_ms_bus  = {m1s_store_flow, m1s_bus_r};

    // request goes out on the edge the item moves into mem
    assign data_req  = m1s_valid && ms_allowin && m1s_access;
    assign data_wr   = mem_pkg::is_store(m1s_op);
    assign data_addr = {m1s_addr[mem_pkg::DATA_WD-1:mem_pkg::OFFSET_WD],
                        {mem_pkg::OFFSET_WD{1'b0}}};

    always_comb begin
        data_wstrb = '0;   // loads write nothing
        data_wdata = '0;
        case (m1s_op)
            mem_pkg::OP_SB: begin
                data_wstrb = 4'b0001 << m1s_offset;
                data_wdata = {4{m1s_rt_value[7:0]}};
            end
            mem_pkg::OP_SH: begin
                data_wstrb = m1s_offset[1] ? 4'b1100 : 4'b0011;
                data_wdata = {2{m1s_rt_value[15:0]}};
            end
            mem_pkg::OP_SW: begin
                data_wstrb = 4'b1111;
                data_wdata = m1s_rt_value;
            end
            mem_pkg::OP_SWL: begin
                // upper bytes of rt land from byte 0 up to the offset
                data_wstrb = 4'b1111 >> (2'd3 - m1s_offset);
                data_wdata = m1s_rt_value >> {2'd3 - m1s_offset, 3'b000};
            end
            mem_pkg::OP_SWR: begin
                // lower bytes of rt land from the offset up to byte 3
                data_wstrb = 4'b1111 << m1s_offset;
                data_wdata = m1s_rt_value << {m1s_offset, 3'b000};
            end
            default: begin
            end
        endcase
    end

endmodule

/* mem_pkg.sv */
package mem_pkg;

    localparam int OP_WD     = 4;
    localparam int STRB_WD   = 4;
    localparam int DATA_WD   = 32;
    localparam int OFFSET_WD = 2;   // byte offset inside a word

    localparam logic [OP_WD-1:0] OP_NONE = 4'd0;

    // loads
    localparam logic [OP_WD-1:0] OP_LB  = 4'd1;
    localparam logic [OP_WD-1:0] OP_LBU = 4'd2;
    localparam logic [OP_WD-1:0] OP_LH  = 4'd3;
    localparam logic [OP_WD-1:0] OP_LHU = 4'd4;
    localparam logic [OP_WD-1:0] OP_LW  = 4'd5;
    localparam logic [OP_WD-1:0] OP_LWL = 4'd6;
    localparam logic [OP_WD-1:0] OP_LWR = 4'd7;

    // stores
    localparam logic [OP_WD-1:0] OP_SB  = 4'd8;
    localparam logic [OP_WD-1:0] OP_SH  = 4'd9;
    localparam logic [OP_WD-1:0] OP_SW  = 4'd10;
    localparam logic [OP_WD-1:0] OP_SWL = 4'd11;
    localparam logic [OP_WD-1:0] OP_SWR = 4'd12;

    function automatic logic is_load(input logic [OP_WD-1:0] op);
        return op inside {OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW, OP_LWL, OP_LWR};
    endfunction

    function automatic logic is_store(input logic [OP_WD-1:0] op);
        return op inside {OP_SB, OP_SH, OP_SW, OP_SWL, OP_SWR};
    endfunction

endpackage

/* mem_stage.sv */
`timescale 1ns/1ps

module mem_stage (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           m1s_to_ms_valid,
    input  logic [pipe_pkg::MS_BUS_WD-1:0] m1s_to_ms_bus,
    input  logic                           ws_allowin,
    input  logic [mem_pkg::DATA_WD-1:0]    data_rdata,
    input  logic                           dcache_busy,
    output logic                           ms_allowin,
    output logic                           ms_to_ws_valid,
    output logic [pipe_pkg::WS_BUS_WD-1:0] ms_to_ws_bus,
    output logic                           ms_load_op,
    output logic [pipe_pkg::DEST_WD-1:0]   fwd_dest,
    output logic [mem_pkg::DATA_WD-1:0]    fwd_result
);

    logic                           ms_valid;
    logic                           ms_ready_go;
    logic [pipe_pkg::MS_BUS_WD-1:0] ms_bus_r;
    logic                           ms_store_flow;
    logic                           ms_ex;
    logic [mem_pkg::OP_WD-1:0]      ms_op;
    logic [mem_pkg::DATA_WD-1:0]    ms_rt_value;
    logic                           ms_load;
    logic                           ms_we;
    logic [pipe_pkg::DEST_WD-1:0]   ms_dest;
    logic [mem_pkg::DATA_WD-1:0]    ms_result;
    logic [pipe_pkg::PC_WD-1:0]     ms_pc;

    assign ms_store_flow = ms_bus_r[pipe_pkg::SFLOW_LO];
    assign ms_ex         = ms_bus_r[pipe_pkg::EX_LO];
    assign ms_op         = ms_bus_r[pipe_pkg::OP_LO +: mem_pkg::OP_WD];
    assign ms_rt_value   = ms_bus_r[pipe_pkg::RT_LO +: mem_pkg::DATA_WD];
    assign ms_load       = ms_bus_r[pipe_pkg::LOAD_LO];
    assign ms_we         = ms_bus_r[pipe_pkg::WE_LO];
    assign ms_dest       = ms_bus_r[pipe_pkg::DEST_LO +: pipe_pkg::DEST_WD];
    assign ms_result     = ms_bus_r[pipe_pkg::RESULT_LO +: mem_pkg::DATA_WD];
    assign ms_pc         = ms_bus_r[pipe_pkg::PC_LO +: pipe_pkg::PC_WD];

    assign ms_ready_go    = ms_store_flow || !dcache_busy;   // loads wait out the cache
    assign ms_allowin     = !ms_valid || (ms_ready_go && ws_allowin);
    assign ms_to_ws_valid = ms_valid && ms_ready_go;

    always_ff @(posedge clk) begin
        if (reset) begin
            ms_valid <= 1'b0;
        end else if (ms_allowin) begin
            ms_valid <= m1s_to_ms_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (m1s_to_ms_valid && ms_allowin) begin
            ms_bus_r <= m1s_to_ms_bus;
        end
    end

    // read data and byte offset ride along for alignment in wb
    assign ms_to_ws_bus = {ms_load,
                           ms_op,
                           ms_rt_value,
                           data_rdata,
                           ms_result[mem_pkg::OFFSET_WD-1:0],
                           ms_ex,
                           ms_we,
                           ms_dest,
                           ms_result,
                           ms_pc};

    assign ms_load_op = ms_valid && ms_load;
    assign fwd_dest   = ms_dest & {pipe_pkg::DEST_WD{ms_to_ws_valid}};
    assign fwd_result = ms_result;   // alu value, load data not merged yet

endmodule

/* mem_subsystem.sv */
`timescale 1ns/1ps

module mem_subsystem (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           es_to_m1s_valid,
    input  logic [pipe_pkg::M1_BUS_WD-1:0] es_to_m1s_bus,
    output logic                           m1s_allowin,
    output logic                           data_req,
    output logic                           data_wr,
    output logic [mem_pkg::DATA_WD-1:0]    data_addr,
    output logic [mem_pkg::STRB_WD-1:0]    data_wstrb,
    output logic [mem_pkg::DATA_WD-1:0]    data_wdata,
    input  logic [mem_pkg::DATA_WD-1:0]    data_rdata,
    input  logic                           dcache_busy,
    input  logic                           retire_ready,
    output logic                           rf_we,
    output logic [pipe_pkg::DEST_WD-1:0]   rf_waddr,
    output logic [mem_pkg::DATA_WD-1:0]    rf_wdata,
    output logic [pipe_pkg::PC_WD-1:0]     retire_pc,
    output logic                           ms_load_op,
    output logic [pipe_pkg::DEST_WD-1:0]   fwd_dest,
    output logic [mem_pkg::DATA_WD-1:0]    fwd_result
);

    logic                           m1s_to_ms_valid;
    logic [pipe_pkg::MS_BUS_WD-1:0] m1s_to_ms_bus;
    logic                           ms_allowin;
    logic                           ms_to_ws_valid;
    logic [pipe_pkg::WS_BUS_WD-1:0] ms_to_ws_bus;
    logic                           ws_allowin;

    mem1_stage u_mem1_stage (
        .clk             (clk),
        .reset           (reset),
        .es_to_m1s_valid (es_to_m1s_valid),
        .es_to_m1s_bus   (es_to_m1s_bus),
        .ms_allowin      (ms_allowin),
        .m1s_allowin     (m1s_allowin),
        .m1s_to_ms_valid (m1s_to_ms_valid),
        .m1s_to_ms_bus   (m1s_to_ms_bus),
        .data_req        (data_req),
        .data_wr         (data_wr),
        .data_addr       (data_addr),
        .data_wstrb      (data_wstrb),
        .data_wdata      (data_wdata)
    );

    mem_stage u_mem_stage (
        .clk             (clk),
        .reset           (reset),
        .m1s_to_ms_valid (m1s_to_ms_valid),
        .m1s_to_ms_bus   (m1s_to_ms_bus),
        .ws_allowin      (ws_allowin),
        .data_rdata      (data_rdata),
        .dcache_busy     (dcache_busy),
        .ms_allowin      (ms_allowin),
        .ms_to_ws_valid  (ms_to_ws_valid),
        .ms_to_ws_bus    (ms_to_ws_bus),
        .ms_load_op      (ms_load_op),
        .fwd_dest        (fwd_dest),
        .fwd_result      (fwd_result)
    );

    wb_stage u_wb_stage (
        .clk            (clk),
        .reset          (reset),
        .ms_to_ws_valid (ms_to_ws_valid),
        .ms_to_ws_bus   (ms_to_ws_bus),
        .retire_ready   (retire_ready),
        .ws_allowin     (ws_allowin),
        .rf_we          (rf_we),
        .rf_waddr       (rf_waddr),
        .rf_wdata       (rf_wdata),
        .retire_pc      (retire_pc)
    );

endmodule

/* pipe_pkg.sv */
package pipe_pkg;

    // flat stage bus widths
    localparam int M1_BUS_WD = 108;
    localparam int MS_BUS_WD = 109;
    localparam int WS_BUS_WD = 142;

    localparam int PC_WD   = 32;
    localparam int DEST_WD = 5;

    // low bit of each field on the es->m1s and m1s->ms buses
    localparam int PC_LO     = 0;
    localparam int RESULT_LO = 32;    // alu result, also the memory address
    localparam int DEST_LO   = 64;
    localparam int WE_LO     = 69;
    localparam int LOAD_LO   = 70;
    localparam int RT_LO     = 71;
    localparam int OP_LO     = 103;
    localparam int EX_LO     = 107;
    localparam int SFLOW_LO  = 108;   // ms bus only

    // ms->ws bus, pc up to we sit where they sit on the m1 bus
    localparam int WS_EX_LO   = 70;
    localparam int OFFSET_LO  = 71;
    localparam int RDATA_LO   = 73;
    localparam int WS_RT_LO   = 105;
    localparam int WS_OP_LO   = 137;
    localparam int WS_LOAD_LO = 141;

endpackage

/* tb_mem_subsystem.sv */
`timescale 1ns/1ps

module tb_mem_subsystem;

    localparam int N_ITEMS   = 300;
    localparam int WAIT_MAX  = 200;
    localparam int DRAIN_MAX = 2000;

    logic                           clk;
    logic                           reset;
    logic                           es_to_m1s_valid;
    logic [pipe_pkg::M1_BUS_WD-1:0] es_to_m1s_bus;
    logic                           m1s_allowin;
    logic                           data_req;
    logic                           data_wr;
    logic [mem_pkg::DATA_WD-1:0]    data_addr;
    logic [mem_pkg::STRB_WD-1:0]    data_wstrb;
    logic [mem_pkg::DATA_WD-1:0]    data_wdata;
    logic [mem_pkg::DATA_WD-1:0]    data_rdata;
    logic                           dcache_busy;
    logic                           retire_ready;
    logic                           rf_we;
    logic [pipe_pkg::DEST_WD-1:0]   rf_waddr;
    logic [mem_pkg::DATA_WD-1:0]    rf_wdata;
    logic [pipe_pkg::PC_WD-1:0]     retire_pc;
    logic                           ms_load_op;
    logic [pipe_pkg::DEST_WD-1:0]   fwd_dest;
    logic [mem_pkg::DATA_WD-1:0]    fwd_result;

    logic [31:0] ref_mem   [0:63];   // program-order view of memory
    logic [31:0] cache_mem [0:63];   // contents seen by the cache model
    logic [5:0]  load_word;
    int          busy_cnt;
    integer      seed;

    // one entry per issued item in issue order
    logic [31:0] it_pc     [0:N_ITEMS-1];
    logic [4:0]  it_dest   [0:N_ITEMS-1];
    logic [31:0] it_result [0:N_ITEMS-1];
    logic        it_load   [0:N_ITEMS-1];
    logic        it_waits  [0:N_ITEMS-1];   // load that waits out dcache_busy in mem
    logic        it_we     [0:N_ITEMS-1];
    logic [31:0] it_wdata  [0:N_ITEMS-1];

    // cache requests still owed by the DUT
    logic        rq_wr    [$];
    logic [31:0] rq_addr  [$];
    logic [3:0]  rq_strb  [$];
    logic [31:0] rq_wdata [$];

    int   n_issued;
    int   n_to_ms;
    int   n_to_ws;
    int   n_retired;
    int   edge_count;
    int   item_idx;
    int   gap;
    int   mem_idx;
    logic prev_reset;
    logic ms_has;
    logic ms_is_load;
    logic ms_fwd;

    mem_subsystem uut (
        .clk             (clk),
        .reset           (reset),
        .es_to_m1s_valid (es_to_m1s_valid),
        .es_to_m1s_bus   (es_to_m1s_bus),
        .m1s_allowin     (m1s_allowin),
        .data_req        (data_req),
        .data_wr         (data_wr),
        .data_addr       (data_addr),
        .data_wstrb      (data_wstrb),
        .data_wdata      (data_wdata),
        .data_rdata      (data_rdata),
        .dcache_busy     (dcache_busy),
        .retire_ready    (retire_ready),
        .rf_we           (rf_we),
        .rf_waddr        (rf_waddr),
        .rf_wdata        (rf_wdata),
        .retire_pc       (retire_pc),
        .ms_load_op      (ms_load_op),
        .fwd_dest        (fwd_dest),
        .fwd_result      (fwd_result)
    );

    assign data_rdata = cache_mem[load_word];

    always #2 clk = ~clk;

    task automatic stop_run();
        $display("Test FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic fail_with(input string msg);
        $display("ERROR: %s", msg);
        stop_run();
    endtask

    task automatic mismatch(input string test, input logic [31:0] expected,
                            input logic [31:0] actual);
        $display("MISMATCH %s: expected %h, actual %h", test, expected, actual);
        stop_run();
    endtask

    task automatic check_eq(input string test, input logic [31:0] expected,
                            input logic [31:0] actual);
        assert (actual === expected) else mismatch(test, expected, actual);
    endtask

    function automatic logic [31:0] strobe_mask(input logic [3:0] strb);
        logic [31:0] m;
        int          b;
        m = '0;
        for (b = 0; b < 4; b++) begin
            if (strb[b]) begin
                m[b*8 +: 8] = 8'hff;
            end
        end
        return m;
    endfunction

    // memory lane b takes rt byte src
    // negative src leaves the lane unwritten
    function automatic void store_lanes(input logic [3:0] op, input logic [1:0] off,
                                        input logic [31:0] rt, output logic [3:0] strb,
                                        output logic [31:0] data);
        int b;
        int src;
        int k;
        strb = '0;
        data = '0;
        k    = off;
        for (b = 0; b < 4; b++) begin
            case (op)
                mem_pkg::OP_SB:  src = (b == k) ? 0 : -1;
                mem_pkg::OP_SH:  src = (b / 2 == k / 2) ? b % 2 : -1;
                mem_pkg::OP_SW:  src = b;
                mem_pkg::OP_SWL: src = (b <= k) ? b + 3 - k : -1;
                mem_pkg::OP_SWR: src = (b >= k) ? b - k : -1;
                default:         src = -1;
            endcase
            if (src >= 0) begin
                strb[b]        = 1'b1;
                data[b*8 +: 8] = rt[src*8 +: 8];
            end
        end
    endfunction

    function automatic logic [31:0] expect_load(input logic [3:0] op, input logic [1:0] off,
                                                input logic [31:0] word,
                                                input logic [31:0] rt);
        logic [7:0]  bt;
        logic [15:0] hw;
        logic [31:0] r;
        int          b;
        int          k;
        k  = off;
        bt = word[k*8 +: 8];
        hw = word[(k/2)*16 +: 16];
        r  = rt;   // lwl/lwr keep the untouched register bytes
        case (op)
            mem_pkg::OP_LB:  r = {{24{bt[7]}}, bt};
            mem_pkg::OP_LBU: r = {24'd0, bt};
            mem_pkg::OP_LH:  r = {{16{hw[15]}}, hw};
            mem_pkg::OP_LHU: r = {16'd0, hw};
            mem_pkg::OP_LWL: begin
                for (b = 0; b <= k; b++) begin
                    r[(b+3-k)*8 +: 8] = word[b*8 +: 8];
                end
            end
            mem_pkg::OP_LWR: begin
                for (b = k; b < 4; b++) begin
                    r[(b-k)*8 +: 8] = word[b*8 +: 8];
                end
            end
            default: r = word;
        endcase
        return r;
    endfunction

    function automatic logic [3:0] pick_op(input int sel);
        case (sel)
            0:       return mem_pkg::OP_NONE;
            1:       return mem_pkg::OP_LB;
            2:       return mem_pkg::OP_LBU;
            3:       return mem_pkg::OP_LH;
            4:       return mem_pkg::OP_LHU;
            5:       return mem_pkg::OP_LW;
            6:       return mem_pkg::OP_LWL;
            7:       return mem_pkg::OP_LWR;
            8:       return mem_pkg::OP_SB;
            9:       return mem_pkg::OP_SH;
            10:      return mem_pkg::OP_SW;
            11:      return mem_pkg::OP_SWL;
            default: return mem_pkg::OP_SWR;
        endcase
    endfunction

    // builds item i, its expected retire values and its cache request
    task automatic make_item(input int i);
        logic [31:0] rnd;
        logic [3:0]  op;
        logic [1:0]  off;
        logic [5:0]  word;
        logic [31:0] rt;
        logic [31:0] result;
        logic [4:0]  dest;
        logic        ex;
        logic        we;
        logic        load;
        logic [3:0]  strb;
        logic [31:0] sdata;
        logic [31:0] mask;
        op   = pick_op({$random(seed)} % 13);
        rnd  = $random(seed);
        word = rnd[5:0];
        off  = rnd[7:6];
        if (op == mem_pkg::OP_LW || op == mem_pkg::OP_SW) begin
            off = 2'd0;
        end
        if (op == mem_pkg::OP_LH || op == mem_pkg::OP_LHU || op == mem_pkg::OP_SH) begin
            off[0] = 1'b0;   // halfwords stay aligned
        end
        dest   = (rnd[10:8] == 3'd0) ? 5'd0 : rnd[15:11];
        ex     = (rnd[18:16] == 3'd0);
        load   = mem_pkg::is_load(op);
        we     = !mem_pkg::is_store(op) && (rnd[21:19] != 3'd0);
        rt     = $random(seed);
        result = $random(seed);
        if (op != mem_pkg::OP_NONE) begin
            result = {24'h100000, word, off};
        end
        it_pc[i]     = 32'hbfc0_0000 + i * 4;
        it_dest[i]   = dest;
        it_result[i] = result;
        it_load[i]   = load;
        it_waits[i]  = load && !ex;
        it_we[i]     = we && (dest != 5'd0) && !ex;
        it_wdata[i]  = load ? expect_load(op, off, ref_mem[word], rt) : result;
        if (!ex && op != mem_pkg::OP_NONE) begin
            store_lanes(op, off, rt, strb, sdata);
            rq_wr.push_back(mem_pkg::is_store(op));
            rq_addr.push_back({result[31:2], 2'b00});
            rq_strb.push_back(strb);
            rq_wdata.push_back(sdata);
            mask          = strobe_mask(strb);   // zero for loads
            ref_mem[word] = (ref_mem[word] & ~mask) | (sdata & mask);
        end
        es_to_m1s_bus = {ex, op, rt, load, we, dest, result, it_pc[i]};
    endtask

    task automatic serve_request();
        logic        wr_exp;
        logic [31:0] addr_exp;
        logic [3:0]  strb_exp;
        logic [31:0] wdata_exp;
        logic [31:0] mask;
        assert (rq_wr.size() != 0) else fail_with("data_req raised with no access pending");
        wr_exp    = rq_wr.pop_front();
        addr_exp  = rq_addr.pop_front();
        strb_exp  = rq_strb.pop_front();
        wdata_exp = rq_wdata.pop_front();
        check_eq("request wr", wr_exp, data_wr);
        check_eq("request addr", addr_exp, data_addr);
        if (wr_exp) begin
            mask = strobe_mask(strb_exp);
            check_eq("store strobe", strb_exp, data_wstrb);
            check_eq("store data", wdata_exp & mask, data_wdata & mask);
            cache_mem[data_addr[7:2]] <= #1 (cache_mem[data_addr[7:2]] & ~mask)
                                            | (data_wdata & mask);
        end else begin
            load_word <= #1 data_addr[7:2];
            busy_cnt   = {$random(seed)} % 6;   // 0 to 5 busy cycles
        end
    endtask

    task automatic wait_accept();
        int cycles;
        cycles = 0;
        @(posedge clk);
        while (m1s_allowin !== 1'b1) begin
            cycles++;
            if (cycles > WAIT_MAX) begin
                fail_with("timeout waiting for mem1 to accept an item");
            end
            @(posedge clk);
        end
    endtask

    task automatic wait_drain();
        int cycles;
        cycles = 0;
        while (n_retired < N_ITEMS) begin
            cycles++;
            if (cycles > DRAIN_MAX) begin
                fail_with("timeout waiting for all items to retire");
            end
            @(posedge clk);
        end
    endtask

    // cache model and commit back-pressure
    always @(posedge clk) begin
        if (reset) begin
            busy_cnt = 0;
        end else begin
            if (busy_cnt > 0) begin
                busy_cnt--;
            end
            if (data_req === 1'b1) begin
                serve_request();
            end
        end
        dcache_busy  <= #1 (busy_cnt != 0);
        retire_ready <= #1 (($random(seed) & 3) != 0);   // ready 3 cycles in 4
    end

    // monitor sees the values of the cycle that ends at this edge
    always @(posedge clk) begin
        edge_count++;
        if ((reset && edge_count > 1) || (prev_reset && !reset)) begin
            assert (data_req === 1'b0 && rf_we === 1'b0 && ms_load_op === 1'b0
                    && fwd_dest === '0)
                else fail_with("an output was not idle during or right after reset");
        end
        prev_reset = reset;
        if (!reset) begin
            assert (!(rf_we === 1'b1 && retire_ready !== 1'b1))
                else fail_with("rf_we high while retire_ready low");
            if (uut.u_wb_stage.ws_valid === 1'b1 && retire_ready === 1'b1) begin
                assert (n_retired < n_issued) else fail_with("an item retired twice");
                check_eq("retire order", it_pc[n_retired], retire_pc);
                check_eq("rf_we", it_we[n_retired], rf_we);
                if (it_we[n_retired]) begin
                    check_eq("rf_waddr", it_dest[n_retired], rf_waddr);
                    if (it_load[n_retired]) begin
                        check_eq("load data", it_wdata[n_retired], rf_wdata);
                    end else begin
                        check_eq("alu data", it_wdata[n_retired], rf_wdata);
                    end
                end
                n_retired++;
            end else begin
                assert (rf_we !== 1'b1) else fail_with("rf_we high with no item retiring");
            end
            ms_has     = (n_to_ms > n_to_ws);
            ms_is_load = ms_has ? it_load[n_to_ws] : 1'b0;
            ms_fwd     = ms_has && !(it_waits[n_to_ws] && dcache_busy === 1'b1);
            check_eq("ms_load_op", ms_is_load, ms_load_op);
            check_eq("fwd_dest", ms_fwd ? it_dest[n_to_ws] : 5'd0, fwd_dest);
            if (ms_fwd) begin
                check_eq("fwd_result", it_result[n_to_ws], fwd_result);
            end
            if (uut.ms_to_ws_valid && uut.ws_allowin) begin
                n_to_ws++;
            end
            if (uut.m1s_to_ms_valid && uut.ms_allowin) begin
                n_to_ms++;
            end
            if (es_to_m1s_valid && m1s_allowin) begin
                n_issued++;
            end
        end
    end

    initial begin
        seed            = 37760;
        clk             = 1'b0;
        reset           = 1'b1;
        es_to_m1s_valid = 1'b0;
        es_to_m1s_bus   = '0;
        dcache_busy     = 1'b0;
        retire_ready    = 1'b0;
        load_word       = '0;
        busy_cnt        = 0;
        n_issued        = 0;
        n_to_ms         = 0;
        n_to_ws         = 0;
        n_retired       = 0;
        edge_count      = 0;
        prev_reset      = 1'b0;
        for (mem_idx = 0; mem_idx < 64; mem_idx++) begin
            ref_mem[mem_idx]   = (mem_idx * 32'h9e37_79b9) ^ {4{mem_idx[7:0]}};
            cache_mem[mem_idx] = ref_mem[mem_idx];
        end
        repeat (16) @(posedge clk);
        #1;
        reset = 1'b0;
        for (item_idx = 0; item_idx < N_ITEMS; item_idx++) begin
            make_item(item_idx);
            es_to_m1s_valid = 1'b1;
            wait_accept();
            #1;
            es_to_m1s_valid = 1'b0;
            gap = (($random(seed) & 3) == 0) ? 1 : 0;   // occasional bubble
            repeat (gap) begin
                @(posedge clk);
                #1;
            end
        end
        wait_drain();
        if (rq_wr.size() != 0) begin
            fail_with("expected cache requests were never issued");
        end else begin
            $display("Test OK");
            $finish;
        end
    end

endmodule

/* wb_stage.sv */
`timescale 1ns/1ps

module wb_stage (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           ms_to_ws_valid,
    input  logic [pipe_pkg::WS_BUS_WD-1:0] ms_to_ws_bus,
    input  logic                           retire_ready,
    output logic                           ws_allowin,
    output logic                           rf_we,
    output logic [pipe_pkg::DEST_WD-1:0]   rf_waddr,
    output logic [mem_pkg::DATA_WD-1:0]    rf_wdata,
    output logic [pipe_pkg::PC_WD-1:0]     retire_pc
);

    logic                           ws_valid;
    logic                           ws_leave;
    logic [pipe_pkg::WS_BUS_WD-1:0] ws_bus_r;
    logic                           ws_load;
    logic [mem_pkg::OP_WD-1:0]      ws_op;
    logic [mem_pkg::DATA_WD-1:0]    ws_rt_value;
    logic [mem_pkg::DATA_WD-1:0]    ws_rdata;
    logic [mem_pkg::OFFSET_WD-1:0]  ws_offset;
    logic                           ws_ex;
    logic                           ws_we;
    logic [pipe_pkg::DEST_WD-1:0]   ws_dest;
    logic [mem_pkg::DATA_WD-1:0]    ws_result;
    logic [pipe_pkg::PC_WD-1:0]     ws_pc;
    logic [mem_pkg::DATA_WD-1:0]    ws_load_data;

    assign ws_load     = ws_bus_r[pipe_pkg::WS_LOAD_LO];
    assign ws_op       = ws_bus_r[pipe_pkg::WS_OP_LO +: mem_pkg::OP_WD];
    assign ws_rt_value = ws_bus_r[pipe_pkg::WS_RT_LO +: mem_pkg::DATA_WD];
    assign ws_rdata    = ws_bus_r[pipe_pkg::RDATA_LO +: mem_pkg::DATA_WD];
    assign ws_offset   = ws_bus_r[pipe_pkg::OFFSET_LO +: mem_pkg::OFFSET_WD];
    assign ws_ex       = ws_bus_r[pipe_pkg::WS_EX_LO];
    assign ws_we       = ws_bus_r[pipe_pkg::WE_LO];
    assign ws_dest     = ws_bus_r[pipe_pkg::DEST_LO +: pipe_pkg::DEST_WD];
    assign ws_result   = ws_bus_r[pipe_pkg::RESULT_LO +: mem_pkg::DATA_WD];
    assign ws_pc       = ws_bus_r[pipe_pkg::PC_LO +: pipe_pkg::PC_WD];

    assign ws_leave   = ws_valid && retire_ready;   // commit back-pressure
    assign ws_allowin = !ws_valid || retire_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            ws_valid <= 1'b0;
        end else if (ws_allowin) begin
            ws_valid <= ms_to_ws_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (ms_to_ws_valid && ws_allowin) begin
            ws_bus_r <= ms_to_ws_bus;
        end
    end

    load_align u_load_align (
        .mem_op    (ws_op),
        .offset    (ws_offset),
        .rdata     (ws_rdata),
        .rt_value  (ws_rt_value),
        .load_data (ws_load_data)
    );

    // r0 is never written
    assign rf_we     = ws_leave && ws_we && (ws_dest != '0) && !ws_ex;
    assign rf_waddr  = ws_dest;
    assign rf_wdata  = ws_load ? ws_load_data : ws_result;
    assign retire_pc = ws_pc;

endmodule
